// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ice_bus
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0 -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== bus_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_interface import ice_pkg::*; #(
	parameter int ADDR = 0,
	parameter int INCLUDE_INPUT_FIFO = 0,
	parameter int INCLUDE_OUTPUT_FIFO = 0,
	parameter int FIFO_DEPTH = 32
) (
	input wire clk,
	input wire rst_n,

	// Master bus
	input wire ma_bus_t ma,
	output logic overflow,

	// Slave bus
	output sl_port_t sl,
	input wire offset_t sl_addr,
	output logic sl_arb_request,
	input wire sl_arb_grant,
	input wire sl_latch_tail,

	// Local input side
	output word_t in_frame_data,
	output offset_t in_frame_tail,
	input wire offset_t in_frame_addr,
	output logic in_frame_valid,
	output logic in_frame_data_valid,
	input wire in_frame_latch_tail,

	// Local output side
	input wire data_t out_frame_data,
	input wire out_frame_valid,
	input wire out_frame_data_latch
);
	logic addr_match;

	assign addr_match = (ma.addr == node_addr_t'(ADDR));

	generate
		if (INCLUDE_INPUT_FIFO != 0) begin : g_in_fifo
			message_fifo #(.DEPTH(FIFO_DEPTH)) in_fifo_i (
				.clk(clk),
				.rst_n(rst_n),
				.in_data(ma.data),
				.in_data_latch(ma.data_valid & addr_match),
				.in_frame_valid(ma.frame_valid & addr_match),
				.in_data_overflow(overflow),
				.tail(in_frame_tail),
				.out_data(in_frame_data),
				.out_data_addr(in_frame_addr),
				.out_frame_valid(in_frame_valid),
				.latch_tail(in_frame_latch_tail)
			);
			// Whole head frame is readable while it is shown
			assign in_frame_data_valid = in_frame_valid;
		end else begin : g_in_pass
			logic last_frame_valid;
			logic insert_eof;

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n)
					last_frame_valid <= 1'b0;
				else
					last_frame_valid <= ma.frame_valid & addr_match;
			end

			// Extra end-of-frame word in the cycle the frame level drops
			assign insert_eof = last_frame_valid & ~(ma.frame_valid & addr_match);
			assign in_frame_data = {insert_eof, ma.data};
			assign in_frame_tail = '0;
			assign in_frame_valid = addr_match & ma.frame_valid;
			assign in_frame_data_valid = (addr_match & ma.data_valid) | insert_eof;
			assign overflow = 1'b0;
		end
	endgenerate

	generate
		if (INCLUDE_OUTPUT_FIFO != 0) begin : g_out_fifo
			// Relay only fills an empty FIFO with a frame that already fit
			message_fifo #(.DEPTH(FIFO_DEPTH)) out_fifo_i (
				.clk(clk),
				.rst_n(rst_n),
				.in_data(out_frame_data),
				.in_data_latch(out_frame_data_latch),
				.in_frame_valid(out_frame_valid),
				.in_data_overflow(),
				.tail(sl.tail),
				.out_data(sl.data),
				.out_data_addr(sl_addr),
				.out_frame_valid(sl_arb_request),
				.latch_tail(sl_latch_tail & sl_arb_grant)
			);
		end else begin : g_out_stub
			assign sl = '0;
			assign sl_arb_request = 1'b0;
		end
	endgenerate

endmodule

`default_nettype wire

// ==== flist.f ====
ice_pkg.sv
message_fifo.sv
bus_interface.sv
frame_relay.sv
slave_bus_arbiter.sv
ice_bus_top.sv
tb_ice_bus.sv

// ==== frame_relay.sv ====
`timescale 1ns/1ps
`default_nettype none

// Moves one frame at a time from the input FIFO to the output FIFO
module frame_relay import ice_pkg::*; (
	input wire clk,
	input wire rst_n,

	// Input FIFO side
	input wire frame_valid,
	input wire word_t frame_data,
	input wire offset_t frame_tail,
	output offset_t frame_addr,
	output logic frame_latch_tail,

	// Output FIFO side
	input wire out_busy,
	output logic out_frame_valid,
	output data_t out_frame_data,
	output logic out_frame_data_latch
);
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_COPY,
		ST_CLOSE,
		ST_POP
	} state_t;

	state_t state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			frame_addr <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					// Wait until the host has taken the previous frame
					if (frame_valid && !out_busy) begin
						state <= ST_COPY;
						frame_addr <= '0;
					end
				end
				ST_COPY: begin
					if (frame_addr == frame_tail)
						state <= ST_CLOSE;
					else
						frame_addr <= frame_addr + 1'b1;
				end
				// Output frame level is low here, so the output FIFO commits
				ST_CLOSE: state <= ST_POP;
				ST_POP: state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	// One byte per cycle from the combinational FIFO read
	assign out_frame_data = frame_data[DATA_W-1:0];
	assign out_frame_valid = (state == ST_COPY);
	assign out_frame_data_latch = (state == ST_COPY);
	assign frame_latch_tail = (state == ST_POP);

endmodule

`default_nettype wire

// ==== ice_bus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ice_bus_top import ice_pkg::*; #(
	parameter int NUM_NODES = 2,
	parameter int FIFO_DEPTH = 32,
	parameter int INCLUDE_INPUT_FIFO = 1,
	parameter int INCLUDE_OUTPUT_FIFO = 1
) (
	input wire clk,
	input wire rst_n,
	input wire ma_bus_t ma,
	output logic overflow,
	input wire offset_t sl_addr,
	input wire sl_latch_tail,
	output logic sl_frame_valid,
	output node_addr_t sl_grant_node,
	output sl_port_t sl_port
);
	logic [NUM_NODES-1:0] node_overflow;
	logic [NUM_NODES-1:0] arb_request;
	logic [NUM_NODES-1:0] arb_grant;
	sl_port_t node_sl [NUM_NODES];

	// Node to relay wiring
	word_t in_data [NUM_NODES];
	offset_t in_tail [NUM_NODES];
	offset_t in_addr [NUM_NODES];
	logic [NUM_NODES-1:0] in_valid;
	logic [NUM_NODES-1:0] in_latch_tail;
	data_t out_data [NUM_NODES];
	logic [NUM_NODES-1:0] out_valid;
	logic [NUM_NODES-1:0] out_latch;

	generate
		for (genvar i = 0; i < NUM_NODES; i++) begin : g_node
			bus_interface #(
				.ADDR(i),
				.INCLUDE_INPUT_FIFO(INCLUDE_INPUT_FIFO),
				.INCLUDE_OUTPUT_FIFO(INCLUDE_OUTPUT_FIFO),
				.FIFO_DEPTH(FIFO_DEPTH)
			) node_i (
				.clk(clk),
				.rst_n(rst_n),
				.ma(ma),
				.overflow(node_overflow[i]),
				.sl(node_sl[i]),
				.sl_addr(sl_addr),
				.sl_arb_request(arb_request[i]),
				.sl_arb_grant(arb_grant[i]),
				.sl_latch_tail(sl_latch_tail),
				.in_frame_data(in_data[i]),
				.in_frame_tail(in_tail[i]),
				.in_frame_addr(in_addr[i]),
				.in_frame_valid(in_valid[i]),
				// Relay reads by offset and has no use for the strobe
				.in_frame_data_valid(),
				.in_frame_latch_tail(in_latch_tail[i]),
				.out_frame_data(out_data[i]),
				.out_frame_valid(out_valid[i]),
				.out_frame_data_latch(out_latch[i])
			);

			frame_relay relay_i (
				.clk(clk),
				.rst_n(rst_n),
				.frame_valid(in_valid[i]),
				.frame_data(in_data[i]),
				.frame_tail(in_tail[i]),
				.frame_addr(in_addr[i]),
				.frame_latch_tail(in_latch_tail[i]),
				.out_busy(arb_request[i]),
				.out_frame_valid(out_valid[i]),
				.out_frame_data(out_data[i]),
				.out_frame_data_latch(out_latch[i])
			);
		end
	endgenerate

	slave_bus_arbiter #(.NUM_NODES(NUM_NODES)) arb_i (
		.clk(clk),
		.rst_n(rst_n),
		.request(arb_request),
		.latch_tail(sl_latch_tail),
		.grant(arb_grant),
		.grant_node(sl_grant_node),
		.busy(sl_frame_valid)
	);

	// Overflow follows the node the host is addressing
	always_comb begin
		overflow = 1'b0;
		for (int n = 0; n < NUM_NODES; n++) begin
			if (ma.addr == node_addr_t'(n))
				overflow = node_overflow[n];
		end
	end

	// Granted node drives the slave bus, zero when nobody holds it
	always_comb begin
		sl_port = '0;
		for (int n = 0; n < NUM_NODES; n++) begin
			if (arb_grant[n])
				sl_port = node_sl[n];
		end
	end

endmodule

`default_nettype wire

// ==== ice_pkg.sv ====
`default_nettype none

package ice_pkg;

	// Payload and storage widths
	localparam int DATA_W = 8;
	localparam int WORD_W = DATA_W + 1;
	localparam int NODE_ADDR_W = 8;
	localparam int OFFSET_W = 9;

	// One payload byte
	typedef logic [DATA_W-1:0] data_t;

	// Stored word, bit 8 marks the last byte of a frame
	typedef logic [WORD_W-1:0] word_t;

	// Node address on the master bus
	typedef logic [NODE_ADDR_W-1:0] node_addr_t;

	// Word offset inside a frame, used for read addresses and tails
	typedef logic [OFFSET_W-1:0] offset_t;

	// Broadcast master bus from the host
	typedef struct packed {
		node_addr_t addr;
		data_t data;
		logic data_valid;
		logic frame_valid;
	} ma_bus_t;

	// Slave bus output of one node
	typedef struct packed {
		word_t data;
		offset_t tail;
	} sl_port_t;

endpackage

`default_nettype wire

// ==== message_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

// Frame FIFO with random-access reads in the head frame.
// DEPTH must be a power of two so the pointers wrap on their own
module message_fifo import ice_pkg::*; #(
	parameter int DEPTH = 32
) (
	input wire clk,
	input wire rst_n,
	input wire data_t in_data,
	input wire in_data_latch,
	input wire in_frame_valid,
	output logic in_data_overflow,
	output offset_t tail,
	output word_t out_data,
	input wire offset_t out_data_addr,
	output logic out_frame_valid,
	input wire latch_tail
);
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = PTR_W + 1;

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	word_t mem [DEPTH];
	// Tails of committed frames, oldest at q_rd
	offset_t tail_q [DEPTH];

	ptr_t head_ptr;
	cnt_t used;
	cnt_t frame_len;
	data_t hold_data;
	logic last_frame_valid;
	ptr_t q_rd;
	ptr_t q_wr;
	cnt_t q_count;

	logic frame_end;
	logic full;
	logic accept;
	logic commit;
	logic pop;
	logic mem_we;
	ptr_t wr_base;
	ptr_t wr_addr;
	offset_t head_tail;
	cnt_t pop_len;

	assign frame_end = last_frame_valid & ~in_frame_valid;

	// Open frame counts the byte still waiting in the hold register
	assign full = (used + frame_len) == cnt_t'(DEPTH);
	assign accept = in_data_latch & in_frame_valid & ~in_data_overflow & ~full;
	assign commit = frame_end & ~in_data_overflow & (frame_len != '0);

	assign out_frame_valid = (q_count != '0);
	assign pop = latch_tail & out_frame_valid;
	assign head_tail = tail_q[q_rd];
	assign pop_len = cnt_t'(head_tail) + 1'b1;
	assign tail = out_frame_valid ? head_tail : '0;

	// Open frame starts right after the committed words
	assign wr_base = head_ptr + ptr_t'(used);
	// Held byte lands in the last slot the open frame has claimed
	assign wr_addr = wr_base + ptr_t'(frame_len) - 1'b1;
	assign mem_we = (accept & (frame_len != '0)) | commit;

	assign out_data = mem[head_ptr + ptr_t'(out_data_addr)];

	always_ff @(posedge clk) begin
		if (mem_we)
			mem[wr_addr] <= {commit, hold_data};
		if (accept)
			hold_data <= in_data;
		if (commit)
			tail_q[q_wr] <= offset_t'(frame_len - 1'b1);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_frame_valid <= 1'b0;
			in_data_overflow <= 1'b0;
			frame_len <= '0;
			head_ptr <= '0;
			used <= '0;
			q_rd <= '0;
			q_wr <= '0;
			q_count <= '0;
		end else begin
			last_frame_valid <= in_frame_valid;

			// Overflow sticks until the frame ends, then the frame is dropped
			if (frame_end)
				in_data_overflow <= 1'b0;
			else if (in_data_latch & in_frame_valid & full)
				in_data_overflow <= 1'b1;

			if (frame_end)
				frame_len <= '0;
			else if (accept)
				frame_len <= frame_len + 1'b1;

			if (pop) begin
				head_ptr <= head_ptr + ptr_t'(pop_len);
				q_rd <= q_rd + 1'b1;
			end
			if (commit)
				q_wr <= q_wr + 1'b1;

			used <= used + (commit ? frame_len : '0) - (pop ? pop_len : '0);
			q_count <= q_count + commit - pop;
		end
	end

endmodule

`default_nettype wire

// ==== slave_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module slave_bus_arbiter import ice_pkg::*; #(
	parameter int NUM_NODES = 2
) (
	input wire clk,
	input wire rst_n,
	input wire [NUM_NODES-1:0] request,
	input wire latch_tail,
	output logic [NUM_NODES-1:0] grant,
	output node_addr_t grant_node,
	output logic busy
);
	typedef logic [NUM_NODES-1:0] mask_t;

	node_addr_t pick;
	logic found;

	// Round-robin search starting after the last winner
	always_comb begin
		int idx;
		pick = grant_node;
		found = 1'b0;
		for (int i = 1; i <= NUM_NODES; i++) begin
			idx = (int'(grant_node) + i) % NUM_NODES;
			if (!found && request[idx]) begin
				pick = node_addr_t'(idx);
				found = 1'b1;
			end
		end
	end

	assign busy = |grant;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant <= '0;
			// First search then begins at node 0
			grant_node <= node_addr_t'(NUM_NODES - 1);
		end else if (busy) begin
			// Released grant leaves one idle cycle before the next one
			if (latch_tail)
				grant <= '0;
		end else if (found) begin
			grant <= mask_t'(1) << pick;
			grant_node <= pick;
		end
	end

endmodule

`default_nettype wire

// ==== tb_ice_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ice_bus import ice_pkg::*; ();
	localparam int NUM_NODES = 2;
	localparam int FIFO_DEPTH = 32;
	localparam int WAIT_LIMIT = 500;

	logic clk = 1'b0;
	logic rst_n;
	ma_bus_t ma;
	offset_t sl_addr;
	logic sl_latch_tail;
	logic overflow;
	logic sl_frame_valid;
	node_addr_t sl_grant_node;
	sl_port_t sl_port;

	// Expected frames per node, bytes flat plus one length per frame
	data_t sent_bytes [NUM_NODES][$];
	int sent_len [NUM_NODES][$];

	int unsigned rng_state = 32'd51145;
	logic expect_overflow = 1'b0;
	logic overflow_seen = 1'b0;

	ice_bus_top #(
		.NUM_NODES(NUM_NODES),
		.FIFO_DEPTH(FIFO_DEPTH),
		.INCLUDE_INPUT_FIFO(1),
		.INCLUDE_OUTPUT_FIFO(1)
	) dut_i (
		.clk(clk),
		.rst_n(rst_n),
		.ma(ma),
		.overflow(overflow),
		.sl_addr(sl_addr),
		.sl_latch_tail(sl_latch_tail),
		.sl_frame_valid(sl_frame_valid),
		.sl_grant_node(sl_grant_node),
		.sl_port(sl_port)
	);

	always #50 clk = ~clk;

	function automatic int unsigned next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state >> 16;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	// Overflow may only show up while an oversized frame is being sent
	always @(negedge clk) begin
		if (rst_n) begin
			assert (!overflow || expect_overflow)
			else abort_run($sformatf("Error at %0t ns: overflow raised unexpectedly", $time));
			if (overflow)
				overflow_seen = 1'b1;
		end
	end

	// Random strobe gaps inside the frame level
	task automatic send_frame(input int node, input int len, input bit keep);
		int sent;
		data_t b;
		sent = 0;
		@(posedge clk);
		ma.addr <= node_addr_t'(node);
		ma.frame_valid <= 1'b1;
		ma.data_valid <= 1'b0;
		while (sent < len) begin
			@(posedge clk);
			if (next_random() % 4 == 0) begin
				ma.data_valid <= 1'b0;
			end else begin
				b = data_t'(next_random());
				ma.data <= b;
				ma.data_valid <= 1'b1;
				sent++;
				if (keep)
					sent_bytes[node].push_back(b);
			end
		end
		@(posedge clk);
		ma.data_valid <= 1'b0;
		ma.frame_valid <= 1'b0;
		// Gap between frames, the FIFO sees the level fall here
		@(posedge clk);
		if (keep)
			sent_len[node].push_back(len);
	endtask

	task automatic read_frame(input int node, input int hold);
		int len;
		int waited;
		data_t exp_byte;
		if (sent_len[node].size() == 0)
			abort_run("Reader was called for a node with no frame expected");
		len = sent_len[node].pop_front();
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
			if (waited > WAIT_LIMIT)
				abort_run("Timeout while waiting for a slave bus grant");
		end while (!sl_frame_valid);

		assert (sl_grant_node == node_addr_t'(node))
		else abort_run($sformatf("Error at %0t ns: grant to node %0d, expected node %0d",
			$time, sl_grant_node, node));
		assert (sl_port.tail == offset_t'(len - 1))
		else abort_run($sformatf("Error at %0t ns: tail %0d, expected %0d",
			$time, sl_port.tail, len - 1));

		for (int k = 0; k < len; k++) begin
			@(posedge clk);
			sl_addr <= offset_t'(k);
			@(negedge clk);
			exp_byte = sent_bytes[node].pop_front();
			assert (sl_frame_valid)
			else abort_run($sformatf("Error at %0t ns: grant lost during read", $time));
			assert (sl_port.data[DATA_W-1:0] == exp_byte)
			else abort_run($sformatf("Error at %0t ns: node %0d offset %0d data %h, expected %h",
				$time, node, k, sl_port.data[DATA_W-1:0], exp_byte));
			assert (sl_port.data[DATA_W] == (k == len - 1))
			else abort_run($sformatf("Error at %0t ns: end mark %b at offset %0d of tail %0d",
				$time, sl_port.data[DATA_W], k, len - 1));
		end

		// Longer hold lets the other node's relay finish
		repeat (hold) @(posedge clk);
		@(posedge clk);
		sl_latch_tail <= 1'b1;
		@(posedge clk);
		sl_latch_tail <= 1'b0;
		@(negedge clk);
		assert (!sl_frame_valid)
		else abort_run($sformatf("Error at %0t ns: no idle cycle after tail latch", $time));
	endtask

	initial begin
		int len;
		rst_n = 1'b0;
		ma = '0;
		sl_addr = '0;
		sl_latch_tail = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		assert (!sl_frame_valid && !overflow)
		else abort_run($sformatf("Error at %0t ns: outputs active after reset", $time));

		// Single frame through node 0
		len = 1 + int'(next_random() % 20);
		send_frame(0, len, 1'b1);
		read_frame(0, 0);

		// Single frame through node 1
		len = 1 + int'(next_random() % 20);
		send_frame(1, len, 1'b1);
		read_frame(1, 0);

		// Both nodes loaded, grants alternate
		for (int n = 0; n < NUM_NODES; n++) begin
			repeat (2) begin
				len = 1 + int'(next_random() % 12);
				send_frame(n, len, 1'b1);
			end
		end
		read_frame(0, 32);
		read_frame(1, 32);
		read_frame(0, 32);
		read_frame(1, 32);

		// Back to back frames keep their order
		repeat (3) begin
			len = 1 + int'(next_random() % 10);
			send_frame(0, len, 1'b1);
		end
		repeat (3) read_frame(0, 0);

		// Oversized frame is dropped, next one passes
		overflow_seen = 1'b0;
		expect_overflow = 1'b1;
		send_frame(1, FIFO_DEPTH + 8, 1'b0);
		expect_overflow = 1'b0;
		assert (overflow_seen)
		else abort_run($sformatf("Error at %0t ns: overflow never raised", $time));
		len = 1 + int'(next_random() % 20);
		send_frame(1, len, 1'b1);
		read_frame(1, 0);

		// Nothing left over on the slave bus
		repeat (64) begin
			@(negedge clk);
			assert (!sl_frame_valid)
			else abort_run($sformatf("Error at %0t ns: stray frame on the slave bus", $time));
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire
